// ==== Makefile ====
# Verilator simulation of the KD-tree search engine
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= kd_tree_search_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RUN_FLAGS ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sources.f ====
+incdir+src
src/kd_pkg.sv
src/kd_level_stage.sv
src/kd_node_access.sv
src/kd_tree_search.sv
tb/kd_tree_search_assertions.sv
tb/kd_tree_search_tb.sv

// ==== src/kd_defines.svh ====
// KD-tree lookup engine: tree depth, patch geometry and node-word layout
`ifndef KD_DEFINES_SVH
`define KD_DEFINES_SVH

// Tree shape
`define KD_DEPTH 6

// Feature patch geometry
`define KD_DIMS   5
`define KD_COMP_W 11

// Node word layout
`define KD_NODE_W     22
`define KD_MEDIAN_LSB 0
`define KD_DIM_LSB    11
`define KD_DIM_W      3   // Dimension index, values above KD_DIMS-1 clamp to the last component

`endif

// ==== src/kd_level_stage.sv ====
// KD-tree level stage holding one level's node words, the per-lane compare and the hand-off
`timescale 1ns/1ps
`include "kd_defines.svh"

module kd_level_stage
  import kd_pkg::*;
#(
  parameter int LEVEL = 0
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wen,
  input  leaf_idx_t  waddr,
  input  node_word_t wdata,
  input  query_t     q_in,
  input  query_t     q_two_in,
  output node_word_t rdata,
  output query_t     q_out,
  output query_t     q_two_out
);

  localparam int NODES = 2 ** LEVEL;
  localparam int IDX_W = (LEVEL == 0) ? 1 : LEVEL;  // Level 0 holds a single node
  localparam int LANES = 2;

  node_word_t nodes [NODES];

  query_t     lane_in   [LANES];
  query_t     lane_out  [LANES];
  node_word_t lane_word [LANES];

  // Steering decision for one node where 1 goes right
  function automatic logic path_bit(node_word_t word, patch_t patch);
    dim_sel_t dim;
    comp_t    median;
    comp_t    comp;
    dim = word[`KD_DIM_LSB +: `KD_DIM_W];
    if (dim > dim_sel_t'(`KD_DIMS - 1)) begin
      dim = dim_sel_t'(`KD_DIMS - 1);  // Out-of-range index picks the last component
    end
    median = word[`KD_MEDIAN_LSB +: `KD_COMP_W];
    comp   = patch[dim * `KD_COMP_W +: `KD_COMP_W];
    return (comp >= median);
  endfunction

  assign lane_in[0] = q_in;
  assign lane_in[1] = q_two_in;
  assign q_out      = lane_out[0];
  assign q_two_out  = lane_out[1];

  // Host read-back port shares the write address
  assign rdata = nodes[waddr[IDX_W-1:0]];

  // Node lookup for each lane
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      lane_word[l] = nodes[lane_in[l].idx[IDX_W-1:0]];
    end
  end

  // Node storage with one word written per strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int n = 0; n < NODES; n++) begin
        nodes[n] <= '0;
      end
    end else if (wen) begin
      nodes[waddr[IDX_W-1:0]] <= wdata;
    end
  end

  // Query moves one level down while idx doubles and takes the path bit
  always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
      if (!rst_n) begin
        lane_out[l].valid <= 1'b0;
      end else begin
        lane_out[l].valid <= lane_in[l].valid;  // Valid bits follow the query down the tree
      end
      lane_out[l].patch <= lane_in[l].patch;
      lane_out[l].idx   <= {lane_in[l].idx[$bits(leaf_idx_t)-2:0],
                            path_bit(lane_word[l], lane_in[l].patch)};
    end
  end

endmodule

// ==== src/kd_node_access.sv ====
// KD-tree node access: heap address to level decode, write enables and read-back register
`timescale 1ns/1ps
`include "kd_defines.svh"

module kd_node_access
  import kd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sender_enable,
  input  node_addr_t           sender_addr,
  input  logic                 wbs_rd_en_i,
  input  node_word_t           level_rdata [`KD_DEPTH],
  output logic [`KD_DEPTH-1:0] level_wen,
  output leaf_idx_t            local_addr,
  output node_word_t           wbs_dat_o
);

  logic [`KD_DEPTH:0] heap_pos;    // Address plus one, top set bit gives the level
  logic [`KD_DEPTH:0] level_base;  // 2^L
  logic [2:0]         level;
  logic               level_ok;

  assign heap_pos = {1'b0, sender_addr} + 1'b1;

  // Priority search for the top set bit
  always_comb begin
    level      = '0;
    level_base = '0;
    for (int b = 0; b <= `KD_DEPTH; b++) begin
      if (heap_pos[b]) begin
        level      = 3'(b);
        level_base = '0;
        level_base[b] = 1'b1;
      end
    end
  end

  // Address 63 lands past the last level
  assign level_ok = (level < 3'(`KD_DEPTH));

  // Node number minus first node of its level
  assign local_addr = leaf_idx_t'(heap_pos - level_base);

  always_comb begin
    for (int l = 0; l < `KD_DEPTH; l++) begin
      level_wen[l] = sender_enable && (level == 3'(l));
    end
  end

  // Read word holds until the next strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wbs_dat_o <= '0;
    end else if (wbs_rd_en_i) begin
      if (level_ok) begin
        wbs_dat_o <= level_rdata[level];
      end else begin
        wbs_dat_o <= '0;
      end
    end
  end

endmodule

// ==== src/kd_pkg.sv ====
// KD-tree lookup engine: shared width types and the per-lane query record
`include "kd_defines.svh"

package kd_pkg;

  // One feature patch, component k in bits 11k+10:11k
  typedef logic [`KD_DIMS*`KD_COMP_W-1:0] patch_t;

  // Component or median value, unsigned
  typedef logic [`KD_COMP_W-1:0] comp_t;

  // Stored node word, spare bits included
  typedef logic [`KD_NODE_W-1:0] node_word_t;

  typedef logic [`KD_DEPTH-1:0] node_addr_t;  // Heap order node number
  typedef logic [`KD_DEPTH-1:0] leaf_idx_t;   // Local index, leaf index after the last level
  typedef logic [`KD_DIM_W-1:0] dim_sel_t;

  // One lane's query as it walks down the tree
  typedef struct packed {
    logic      valid;
    patch_t    patch;
    leaf_idx_t idx;
  } query_t;

endpackage

// ==== src/kd_tree_search.sv ====
// KD-tree search top: six pipelined level stages for two lanes plus host node access
`timescale 1ns/1ps
`include "kd_defines.svh"

module kd_tree_search
  import kd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sender_enable,
  input  node_word_t sender_data,
  input  node_addr_t sender_addr,
  input  logic       patch_en,
  input  logic       patch_two_en,
  input  patch_t     patch_in,
  input  patch_t     patch_in_two,
  input  logic       wbs_rd_en_i,
  output leaf_idx_t  leaf_index,
  output leaf_idx_t  leaf_index_two,
  output logic       receiver_en,
  output logic       receiver_two_en,
  output node_word_t wbs_dat_o
);

  // Entry L feeds stage L, the last entry is the result
  query_t lane_one [`KD_DEPTH+1];
  query_t lane_two [`KD_DEPTH+1];

  logic [`KD_DEPTH-1:0] level_wen;
  leaf_idx_t            local_addr;
  node_word_t           level_rdata [`KD_DEPTH];

  // Queries enter at the root with local index zero
  assign lane_one[0] = '{valid: patch_en, patch: patch_in, idx: '0};
  assign lane_two[0] = '{valid: patch_two_en, patch: patch_in_two, idx: '0};

  for (genvar lvl = 0; lvl < `KD_DEPTH; lvl++) begin : g_level
    kd_level_stage #(
      .LEVEL(lvl)
    ) u_stage (
      .clk      (clk),
      .rst_n    (rst_n),
      .wen      (level_wen[lvl]),
      .waddr    (local_addr),
      .wdata    (sender_data),
      .q_in     (lane_one[lvl]),
      .q_two_in (lane_two[lvl]),
      .rdata    (level_rdata[lvl]),
      .q_out    (lane_one[lvl+1]),
      .q_two_out(lane_two[lvl+1])
    );
  end

  kd_node_access u_access (
    .clk          (clk),
    .rst_n        (rst_n),
    .sender_enable(sender_enable),
    .sender_addr  (sender_addr),
    .wbs_rd_en_i  (wbs_rd_en_i),
    .level_rdata  (level_rdata),
    .level_wen    (level_wen),
    .local_addr   (local_addr),
    .wbs_dat_o    (wbs_dat_o)
  );

  assign receiver_en     = lane_one[`KD_DEPTH].valid;
  assign receiver_two_en = lane_two[`KD_DEPTH].valid;
  assign leaf_index      = lane_one[`KD_DEPTH].idx;  // Stale between strobes
  assign leaf_index_two  = lane_two[`KD_DEPTH].idx;

endmodule

// ==== tb/kd_tree_search_assertions.sv ====
// KD-tree search checker: shadow node table, per-level lane model and output assertions
`timescale 1ns/1ps
`include "kd_defines.svh"

module kd_tree_search_assertions
  import kd_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       sender_enable,
  input node_word_t sender_data,
  input node_addr_t sender_addr,
  input logic       patch_en,
  input logic       patch_two_en,
  input patch_t     patch_in,
  input patch_t     patch_in_two,
  input logic       wbs_rd_en_i,
  input leaf_idx_t  leaf_index,
  input leaf_idx_t  leaf_index_two,
  input logic       receiver_en,
  input logic       receiver_two_en,
  input node_word_t wbs_dat_o
);

  localparam int NODE_COUNT = (1 << `KD_DEPTH) - 1;
  localparam int LAST = `KD_DEPTH - 1;

  int         fail_count = 0;
  node_word_t shadow [NODE_COUNT];
  node_word_t rd_expect;            // Word the last read strobe should return
  logic       entry_en    [2];
  patch_t     entry_patch [2];
  // Lane model, entry L holds the query after level L
  logic       m_valid [2][`KD_DEPTH];
  patch_t     m_patch [2][`KD_DEPTH];
  leaf_idx_t  m_idx   [2][`KD_DEPTH];

  // Right branch when the chosen component reaches the median
  function automatic logic goes_right(node_word_t word, patch_t patch);
    int dim;
    dim = int'(word[`KD_DIM_LSB +: 3]);
    if (dim > `KD_DIMS - 1) begin
      dim = `KD_DIMS - 1;
    end
    return patch[dim * `KD_COMP_W +: `KD_COMP_W] >= word[`KD_MEDIAN_LSB +: `KD_COMP_W];
  endfunction

  assign entry_en[0]    = patch_en;
  assign entry_en[1]    = patch_two_en;
  assign entry_patch[0] = patch_in;
  assign entry_patch[1] = patch_in_two;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NODE_COUNT; i++) begin
        shadow[i] <= '0;
      end
    end else if (sender_enable && int'(sender_addr) < NODE_COUNT) begin
      shadow[sender_addr] <= sender_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_expect <= '0;
    end else if (wbs_rd_en_i) begin
      rd_expect <= (int'(sender_addr) < NODE_COUNT) ? shadow[sender_addr] : '0;
    end
  end

  // Each level reads the shadow as it stood before this edge's write
  always_ff @(posedge clk) begin
    for (int ln = 0; ln < 2; ln++) begin
      m_valid[ln][0] <= rst_n && entry_en[ln];
      m_patch[ln][0] <= entry_patch[ln];
      m_idx[ln][0]   <= leaf_idx_t'(goes_right(shadow[0], entry_patch[ln]));
      for (int lv = 1; lv < `KD_DEPTH; lv++) begin
        m_valid[ln][lv] <= rst_n && m_valid[ln][lv-1];
        m_patch[ln][lv] <= m_patch[ln][lv-1];
        m_idx[ln][lv]   <= leaf_idx_t'(2 * int'(m_idx[ln][lv-1]) + int'(goes_right(
                             shadow[(1 << lv) - 1 + int'(m_idx[ln][lv-1])], m_patch[ln][lv-1])));
      end
    end
  end

  a_reset_clear: assert property (@(posedge clk)
      !rst_n |=> (!receiver_en && !receiver_two_en && wbs_dat_o == '0))
    else begin
      fail_count++;
      $error("[FAIL] %0t receiver_en/receiver_two_en/wbs_dat_o expected 0/0/0 actual %0b/%0b/%0h",
             $time, $sampled(receiver_en), $sampled(receiver_two_en), $sampled(wbs_dat_o));
    end

  a_valid_one: assert property (@(posedge clk) disable iff (!rst_n)
      receiver_en == m_valid[0][LAST])
    else begin
      fail_count++;
      $error("[FAIL] %0t receiver_en expected %0b actual %0b",
             $time, $sampled(m_valid[0][LAST]), $sampled(receiver_en));
    end

  a_valid_two: assert property (@(posedge clk) disable iff (!rst_n)
      receiver_two_en == m_valid[1][LAST])
    else begin
      fail_count++;
      $error("[FAIL] %0t receiver_two_en expected %0b actual %0b",
             $time, $sampled(m_valid[1][LAST]), $sampled(receiver_two_en));
    end

  a_leaf_one: assert property (@(posedge clk) disable iff (!rst_n)
      receiver_en |-> leaf_index == m_idx[0][LAST])
    else begin
      fail_count++;
      $error("[FAIL] %0t leaf_index expected %0d actual %0d",
             $time, $sampled(m_idx[0][LAST]), $sampled(leaf_index));
    end

  a_leaf_two: assert property (@(posedge clk) disable iff (!rst_n)
      receiver_two_en |-> leaf_index_two == m_idx[1][LAST])
    else begin
      fail_count++;
      $error("[FAIL] %0t leaf_index_two expected %0d actual %0d",
             $time, $sampled(m_idx[1][LAST]), $sampled(leaf_index_two));
    end

  a_read_word: assert property (@(posedge clk) disable iff (!rst_n)
      wbs_dat_o == rd_expect)
    else begin
      fail_count++;
      $error("[FAIL] %0t wbs_dat_o expected %06h actual %06h",
             $time, $sampled(rd_expect), $sampled(wbs_dat_o));
    end

endmodule

// ==== tb/kd_tree_search_tb.sv ====
// KD-tree search testbench with random node tables, two-lane patch bursts and rewrites in flight
`timescale 1ns/1ps

module kd_tree_search_tb
  import kd_pkg::*;
();

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 16;
  localparam int BURST_CYCLES   = 400;
  localparam int REWRITE_ROUNDS = 24;
  localparam int TAIL_CYCLES    = 200;
  // Load, read-back, bursts with gaps, rewrite rounds, tail and drain
  localparam int TEST_CYCLES = RESET_CYCLES + 63 + 64 + BURST_CYCLES * 2 +
                               REWRITE_ROUNDS * 6 + TAIL_CYCLES + 16;

  logic       clk;
  logic       rst_n;
  logic       sender_enable;
  node_word_t sender_data;
  node_addr_t sender_addr;
  logic       patch_en;
  logic       patch_two_en;
  patch_t     patch_in;
  patch_t     patch_in_two;
  logic       wbs_rd_en_i;
  leaf_idx_t  leaf_index;
  leaf_idx_t  leaf_index_two;
  logic       receiver_en;
  logic       receiver_two_en;
  node_word_t wbs_dat_o;

  logic [31:0] lcg_state = 32'h76fdd6e6;

  kd_tree_search dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .sender_enable  (sender_enable),
    .sender_data    (sender_data),
    .sender_addr    (sender_addr),
    .patch_en       (patch_en),
    .patch_two_en   (patch_two_en),
    .patch_in       (patch_in),
    .patch_in_two   (patch_in_two),
    .wbs_rd_en_i    (wbs_rd_en_i),
    .leaf_index     (leaf_index),
    .leaf_index_two (leaf_index_two),
    .receiver_en    (receiver_en),
    .receiver_two_en(receiver_two_en),
    .wbs_dat_o      (wbs_dat_o)
  );

  bind kd_tree_search kd_tree_search_assertions u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .sender_enable  (sender_enable),
    .sender_data    (sender_data),
    .sender_addr    (sender_addr),
    .patch_en       (patch_en),
    .patch_two_en   (patch_two_en),
    .patch_in       (patch_in),
    .patch_in_two   (patch_in_two),
    .wbs_rd_en_i    (wbs_rd_en_i),
    .leaf_index     (leaf_index),
    .leaf_index_two (leaf_index_two),
    .receiver_en    (receiver_en),
    .receiver_two_en(receiver_two_en),
    .wbs_dat_o      (wbs_dat_o)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Median, dimension index 0-7 and spare bits all random
  function automatic node_word_t random_word();
    return node_word_t'(next_random());
  endfunction

  // One clock of host and lane activity with fresh random patches
  task automatic drive_cycle(input logic wr, input node_addr_t addr, input node_word_t data,
                             input logic rd, input logic en_one, input logic en_two);
    patch_t p_one;
    patch_t p_two;
    p_one = patch_t'({next_random(), next_random()});
    p_two = patch_t'({next_random(), next_random()});
    @(posedge clk);
    sender_enable <= wr;
    sender_addr   <= addr;
    sender_data   <= data;
    wbs_rd_en_i   <= rd;
    patch_en      <= en_one;
    patch_two_en  <= en_two;
    patch_in      <= p_one;
    patch_in_two  <= p_two;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TEST_CYCLES * CLK_PERIOD + 1000);
    $display("TB FAILED");
    $fatal(1, "Watchdog timeout: stimulus did not finish within %0d cycles", TEST_CYCLES);
  end

  // Stop at the first assertion failure
  always @(posedge clk) begin
    if (dut0.u_chk.fail_count != 0) begin
      $display("TB FAILED");
      $fatal(1, "Checker reported an assertion failure");
    end
  end

  initial begin
    int          n;
    logic [31:0] r;
    node_addr_t  target;
    rst_n         = 1'b0;
    sender_enable = 1'b0;
    sender_data   = '0;
    sender_addr   = '0;
    wbs_rd_en_i   = 1'b0;
    patch_en      = 1'b0;
    patch_two_en  = 1'b0;
    patch_in      = '0;
    patch_in_two  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (n = 0; n < 63; n++) begin
      drive_cycle(1'b1, node_addr_t'(n), random_word(), 1'b0, 1'b0, 1'b0);
    end
    for (n = 0; n < 64; n++) begin
      drive_cycle(1'b0, node_addr_t'(n), '0, 1'b1, 1'b0, 1'b0);  // 63 is past the tree
    end

    // Random bursts with an idle gap every 32 cycles
    for (n = 0; n < BURST_CYCLES; n++) begin
      r = next_random();
      if (n % 32 == 31) begin
        repeat (r[2:0]) drive_cycle(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
      end
      drive_cycle(1'b0, '0, '0, 1'b0, r[7:4] < 4'd11, r[11:8] < 4'd10);
    end

    // Rewrite single nodes with queries still in the pipeline
    for (n = 0; n < REWRITE_ROUNDS; n++) begin
      r = next_random();
      target = node_addr_t'(r[15:10] % 63);
      repeat (3) drive_cycle(1'b0, '0, '0, 1'b0, 1'b1, r[8]);
      drive_cycle(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
      drive_cycle(1'b1, target, random_word(), 1'b0, 1'b0, 1'b0);
      drive_cycle(1'b0, target, '0, 1'b1, r[9], r[9]);
    end

    for (n = 0; n < TAIL_CYCLES; n++) begin
      r = next_random();
      drive_cycle(1'b0, '0, '0, 1'b0, r[20], r[21] | r[22]);
    end
    repeat (10) drive_cycle(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);  // Drain the pipeline
    @(negedge clk);

    if (dut0.u_chk.fail_count != 0) begin
      $display("TB FAILED");
      $fatal(1, "Checker reported %0d assertion failures", dut0.u_chk.fail_count);
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule
